// File: design/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    localparam int cp0_sel_w = 5;

    // register numbers as seen by mtc0/mfc0
    localparam logic [cp0_sel_w-1:0] cp0_sel_index    = 5'd0;
    localparam logic [cp0_sel_w-1:0] cp0_sel_entrylo0 = 5'd2;
    localparam logic [cp0_sel_w-1:0] cp0_sel_entrylo1 = 5'd3;
    localparam logic [cp0_sel_w-1:0] cp0_sel_entryhi  = 5'd10;

    // entryhi layout
    localparam int cp0_entryhi_vpn2_lsb = 13;   // vpn2 runs up to bit 31
    localparam int cp0_entryhi_asid_lsb = 0;

    // entrylo0 / entrylo1 share one layout
    localparam int cp0_entrylo_pfn_lsb = 6;     // pfn in 25:6
    localparam int cp0_entrylo_c_lsb   = 3;
    localparam int cp0_entrylo_d_bit   = 2;
    localparam int cp0_entrylo_v_bit   = 1;
    localparam int cp0_entrylo_g_bit   = 0;

    // index layout
    localparam int cp0_index_p_bit = 31;        // probe failure
    localparam int cp0_index_lsb   = 0;

endpackage

`default_nettype wire

// File: design/cp0_tlb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_tlb_regs (
    input  logic                              aclk,
    input  logic                              reset,

    // mtc0 / mfc0
    input  logic                              mtc0,
    input  logic [cp0_pkg::cp0_sel_w-1:0]     wsel,
    input  logic [31:0]                       wdata,
    input  logic [cp0_pkg::cp0_sel_w-1:0]     rsel,
    output logic [31:0]                       rdata,

    // tlbp, result comes back from the probe port a cycle later
    input  logic                              tlbp,
    input  logic                              probe_found,
    input  logic [tlb_pkg::tlb_index_w-1:0]   probe_index,

    // register fields towards the array and search ports
    output logic [tlb_pkg::vpn2_w-1:0]        entryhi_vpn2,
    output logic [tlb_pkg::asid_w-1:0]        entryhi_asid,
    output logic [tlb_pkg::pfn_w-1:0]         lo0_pfn,
    output logic [tlb_pkg::cattr_w-1:0]       lo0_c,
    output logic                              lo0_d,
    output logic                              lo0_v,
    output logic                              lo0_g,
    output logic [tlb_pkg::pfn_w-1:0]         lo1_pfn,
    output logic [tlb_pkg::cattr_w-1:0]       lo1_c,
    output logic                              lo1_d,
    output logic                              lo1_v,
    output logic                              lo1_g,
    output logic [tlb_pkg::tlb_index_w-1:0]   index_value
);

    import tlb_pkg::*;
    import cp0_pkg::*;

    logic index_p;      // probe failure flag, only tlbp touches it
    logic tlbp_q;       // probe in flight

    always_ff @(posedge aclk) begin
        if (reset) begin
            entryhi_vpn2 <= '0;
            entryhi_asid <= '0;
            lo0_pfn      <= '0;
            lo0_c        <= '0;
            lo0_d        <= 1'b0;
            lo0_v        <= 1'b0;
            lo0_g        <= 1'b0;
            lo1_pfn      <= '0;
            lo1_c        <= '0;
            lo1_d        <= 1'b0;
            lo1_v        <= 1'b0;
            lo1_g        <= 1'b0;
            index_value  <= '0;
            index_p      <= 1'b0;
            tlbp_q       <= 1'b0;
        end else begin
            tlbp_q <= tlbp;
            if (mtc0) begin
                case (wsel)
                    cp0_sel_entryhi: begin
                        entryhi_vpn2 <= wdata[cp0_entryhi_vpn2_lsb +: vpn2_w];
                        entryhi_asid <= wdata[cp0_entryhi_asid_lsb +: asid_w];
                    end
                    cp0_sel_entrylo0: begin
                        lo0_pfn <= wdata[cp0_entrylo_pfn_lsb +: pfn_w];
                        lo0_c   <= wdata[cp0_entrylo_c_lsb +: cattr_w];
                        lo0_d   <= wdata[cp0_entrylo_d_bit];
                        lo0_v   <= wdata[cp0_entrylo_v_bit];
                        lo0_g   <= wdata[cp0_entrylo_g_bit];
                    end
                    cp0_sel_entrylo1: begin
                        lo1_pfn <= wdata[cp0_entrylo_pfn_lsb +: pfn_w];
                        lo1_c   <= wdata[cp0_entrylo_c_lsb +: cattr_w];
                        lo1_d   <= wdata[cp0_entrylo_d_bit];
                        lo1_v   <= wdata[cp0_entrylo_v_bit];
                        lo1_g   <= wdata[cp0_entrylo_g_bit];
                    end
                    cp0_sel_index: begin
                        index_value <= wdata[cp0_index_lsb +: tlb_index_w];
                    end
                    default: ;
                endcase
            end
            // probe result overrides an mtc0 to index on the same edge
            if (tlbp_q) begin
                index_p <= ~probe_found;
                if (probe_found) begin
                    index_value <= probe_index;
                end
            end
        end
    end

    // mfc0 read, unused bits and unknown selectors give zero
    always_comb begin
        rdata = '0;
        case (rsel)
            cp0_sel_entryhi: begin
                rdata[cp0_entryhi_vpn2_lsb +: vpn2_w] = entryhi_vpn2;
                rdata[cp0_entryhi_asid_lsb +: asid_w] = entryhi_asid;
            end
            cp0_sel_entrylo0: begin
                rdata[cp0_entrylo_pfn_lsb +: pfn_w] = lo0_pfn;
                rdata[cp0_entrylo_c_lsb +: cattr_w] = lo0_c;
                rdata[cp0_entrylo_d_bit]            = lo0_d;
                rdata[cp0_entrylo_v_bit]            = lo0_v;
                rdata[cp0_entrylo_g_bit]            = lo0_g;
            end
            cp0_sel_entrylo1: begin
                rdata[cp0_entrylo_pfn_lsb +: pfn_w] = lo1_pfn;
                rdata[cp0_entrylo_c_lsb +: cattr_w] = lo1_c;
                rdata[cp0_entrylo_d_bit]            = lo1_d;
                rdata[cp0_entrylo_v_bit]            = lo1_v;
                rdata[cp0_entrylo_g_bit]            = lo1_g;
            end
            cp0_sel_index: begin
                rdata[cp0_index_p_bit]                = index_p;
                rdata[cp0_index_lsb +: tlb_index_w]   = index_value;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/mmu_top.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_top #(
    parameter int tlb_entries = tlb_pkg::tlb_entries
) (
    input  logic                              aclk,
    input  logic                              reset,

    input  logic                              mtc0,
    input  logic [cp0_pkg::cp0_sel_w-1:0]     cp0_wsel,
    input  logic [31:0]                       cp0_wdata,
    input  logic [cp0_pkg::cp0_sel_w-1:0]     cp0_rsel,
    output logic [31:0]                       cp0_rdata,
    input  logic                              tlbwi,
    input  logic                              tlbp,

    // fetch side lookup
    input  logic [31:0]                       inst_vaddr,
    output logic                              inst_found,
    output logic [31:0]                       inst_paddr,
    output logic [tlb_pkg::cattr_w-1:0]       inst_c,
    output logic                              inst_d,
    output logic                              inst_v,

    // load/store side lookup
    input  logic [31:0]                       data_vaddr,
    output logic                              data_found,
    output logic [31:0]                       data_paddr,
    output logic [tlb_pkg::cattr_w-1:0]       data_c,
    output logic                              data_d,
    output logic                              data_v
);

    import tlb_pkg::*;

    logic [vpn2_w-1:0]      entryhi_vpn2;
    logic [asid_w-1:0]      entryhi_asid;
    logic [pfn_w-1:0]       lo0_pfn;
    logic [cattr_w-1:0]     lo0_c;
    logic                   lo0_d;
    logic                   lo0_v;
    logic                   lo0_g;
    logic [pfn_w-1:0]       lo1_pfn;
    logic [cattr_w-1:0]     lo1_c;
    logic                   lo1_d;
    logic                   lo1_v;
    logic                   lo1_g;
    logic [tlb_index_w-1:0] tlb_windex;
    logic                   probe_found;
    logic [tlb_index_w-1:0] probe_index;

    tlb_entry_t [tlb_entries-1:0] entries;

    cp0_tlb_regs u_cp0 (
        .aclk         (aclk),
        .reset        (reset),
        .mtc0         (mtc0),
        .wsel         (cp0_wsel),
        .wdata        (cp0_wdata),
        .rsel         (cp0_rsel),
        .rdata        (cp0_rdata),
        .tlbp         (tlbp),
        .probe_found  (probe_found),
        .probe_index  (probe_index),
        .entryhi_vpn2 (entryhi_vpn2),
        .entryhi_asid (entryhi_asid),
        .lo0_pfn      (lo0_pfn),
        .lo0_c        (lo0_c),
        .lo0_d        (lo0_d),
        .lo0_v        (lo0_v),
        .lo0_g        (lo0_g),
        .lo1_pfn      (lo1_pfn),
        .lo1_c        (lo1_c),
        .lo1_d        (lo1_d),
        .lo1_v        (lo1_v),
        .lo1_g        (lo1_g),
        .index_value  (tlb_windex)
    );

    tlb_entry_array #(
        .tlb_entries (tlb_entries)
    ) u_array (
        .aclk     (aclk),
        .reset    (reset),
        .tlbwi    (tlbwi),
        .windex   (tlb_windex),
        .wvpn2    (entryhi_vpn2),
        .wasid    (entryhi_asid),
        .wlo0_pfn (lo0_pfn),
        .wlo0_c   (lo0_c),
        .wlo0_d   (lo0_d),
        .wlo0_v   (lo0_v),
        .wlo0_g   (lo0_g),
        .wlo1_pfn (lo1_pfn),
        .wlo1_c   (lo1_c),
        .wlo1_d   (lo1_d),
        .wlo1_v   (lo1_v),
        .wlo1_g   (lo1_g),
        .entries  (entries)
    );

    tlb_search_port #(
        .tlb_entries (tlb_entries)
    ) u_inst_port (
        .aclk     (aclk),
        .reset    (reset),
        .entries  (entries),
        .vpn2     (inst_vaddr[31 -: vpn2_w]),
        .odd_page (inst_vaddr[page_off_w]),
        .asid     (entryhi_asid),
        .offset   (inst_vaddr[page_off_w-1:0]),
        .found    (inst_found),
        .index    (),
        .paddr    (inst_paddr),
        .c        (inst_c),
        .d        (inst_d),
        .v        (inst_v)
    );

    tlb_search_port #(
        .tlb_entries (tlb_entries)
    ) u_data_port (
        .aclk     (aclk),
        .reset    (reset),
        .entries  (entries),
        .vpn2     (data_vaddr[31 -: vpn2_w]),
        .odd_page (data_vaddr[page_off_w]),
        .asid     (entryhi_asid),
        .offset   (data_vaddr[page_off_w-1:0]),
        .found    (data_found),
        .index    (),
        .paddr    (data_paddr),
        .c        (data_c),
        .d        (data_d),
        .v        (data_v)
    );

    // tlbp compare, runs on entryhi every cycle
    tlb_search_port #(
        .tlb_entries (tlb_entries)
    ) u_probe_port (
        .aclk     (aclk),
        .reset    (reset),
        .entries  (entries),
        .vpn2     (entryhi_vpn2),
        .odd_page (1'b0),
        .asid     (entryhi_asid),
        .offset   ('0),
        .found    (probe_found),
        .index    (probe_index),
        .paddr    (),
        .c        (),
        .d        (),
        .v        ()
    );

endmodule

`default_nettype wire

// File: design/tlb_entry_array.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_entry_array #(
    parameter int tlb_entries = tlb_pkg::tlb_entries
) (
    input  logic                                  aclk,
    input  logic                                  reset,

    // tlbwi write side, straight from the cp0 registers
    input  logic                                  tlbwi,
    input  logic [tlb_pkg::tlb_index_w-1:0]       windex,
    input  logic [tlb_pkg::vpn2_w-1:0]            wvpn2,
    input  logic [tlb_pkg::asid_w-1:0]            wasid,
    input  logic [tlb_pkg::pfn_w-1:0]             wlo0_pfn,
    input  logic [tlb_pkg::cattr_w-1:0]           wlo0_c,
    input  logic                                  wlo0_d,
    input  logic                                  wlo0_v,
    input  logic                                  wlo0_g,
    input  logic [tlb_pkg::pfn_w-1:0]             wlo1_pfn,
    input  logic [tlb_pkg::cattr_w-1:0]           wlo1_c,
    input  logic                                  wlo1_d,
    input  logic                                  wlo1_v,
    input  logic                                  wlo1_g,

    // every entry, flat, for the parallel compare in the search ports
    output tlb_pkg::tlb_entry_t [tlb_entries-1:0] entries
);

    import tlb_pkg::*;

    tlb_entry_t wentry;     // entry image assembled from the registers

    always_comb begin
        wentry.vpn2 = wvpn2;
        wentry.asid = wasid;
        wentry.g    = wlo0_g & wlo1_g;  // global only when both halves agree
        wentry.pfn0 = wlo0_pfn;
        wentry.c0   = wlo0_c;
        wentry.d0   = wlo0_d;
        wentry.v0   = wlo0_v;
        wentry.pfn1 = wlo1_pfn;
        wentry.c1   = wlo1_c;
        wentry.d1   = wlo1_d;
        wentry.v1   = wlo1_v;
    end

    // one write port, visible to lookups from the next edge on
    always_ff @(posedge aclk) begin
        if (reset) begin
            entries <= '0;
        end else if (tlbwi) begin
            entries[windex] <= wentry;
        end
    end

endmodule

`default_nettype wire

// File: design/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // geometry
    localparam int tlb_entries = 16;
    localparam int tlb_index_w = $clog2(tlb_entries);

    // virtual side
    localparam int vpn2_w     = 19;   // va[31:13], one even/odd page pair
    localparam int asid_w     = 8;
    localparam int page_off_w = 12;   // 4 KB pages

    // physical side
    localparam int pfn_w   = 20;
    localparam int cattr_w = 3;

    // one joint TLB entry
    // the even half maps va[12] == 0, the odd half va[12] == 1
    typedef struct packed {
        logic [vpn2_w-1:0]  vpn2;
        logic [asid_w-1:0]  asid;
        logic               g;      // global, asid not compared
        logic [pfn_w-1:0]   pfn0;
        logic [cattr_w-1:0] c0;
        logic               d0;     // dirty, i.e. writable
        logic               v0;
        logic [pfn_w-1:0]   pfn1;
        logic [cattr_w-1:0] c1;
        logic               d1;
        logic               v1;
    } tlb_entry_t;

endpackage

`default_nettype wire

// File: design/tlb_search_port.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_search_port #(
    parameter int tlb_entries = tlb_pkg::tlb_entries
) (
    input  logic                                  aclk,
    input  logic                                  reset,
    input  tlb_pkg::tlb_entry_t [tlb_entries-1:0] entries,

    // request, sampled every edge
    input  logic [tlb_pkg::vpn2_w-1:0]            vpn2,
    input  logic                                  odd_page,
    input  logic [tlb_pkg::asid_w-1:0]            asid,
    input  logic [tlb_pkg::page_off_w-1:0]        offset,

    // registered translation
    output logic                                  found,
    output logic [tlb_pkg::tlb_index_w-1:0]       index,
    output logic [31:0]                           paddr,
    output logic [tlb_pkg::cattr_w-1:0]           c,
    output logic                                  d,
    output logic                                  v
);

    import tlb_pkg::*;

    logic [tlb_entries-1:0] match;
    logic                   hit;
    logic [tlb_index_w-1:0] hit_idx;
    tlb_entry_t             hit_entry;
    logic [pfn_w-1:0]       hit_pfn;
    logic [cattr_w-1:0]     hit_c;
    logic                   hit_d;
    logic                   hit_v;

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            match[i] = (entries[i].vpn2 == vpn2) &&
                       (entries[i].g || (entries[i].asid == asid));
        end
    end

    // scan from the top down so the lowest matching entry is the one kept
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit     = 1'b1;
                hit_idx = tlb_index_w'(i);
            end
        end
    end

    assign hit_entry = entries[hit_idx];

    // even or odd half by va[12]
    always_comb begin
        if (odd_page) begin
            hit_pfn = hit_entry.pfn1;
            hit_c   = hit_entry.c1;
            hit_d   = hit_entry.d1;
            hit_v   = hit_entry.v1;
        end else begin
            hit_pfn = hit_entry.pfn0;
            hit_c   = hit_entry.c0;
            hit_d   = hit_entry.d0;
            hit_v   = hit_entry.v0;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset || !hit) begin
            found <= 1'b0;      // a miss reads as all zeros
            index <= '0;
            paddr <= '0;
            c     <= '0;
            d     <= 1'b0;
            v     <= 1'b0;
        end else begin
            found <= 1'b1;
            index <= hit_idx;
            paddr <= {hit_pfn, offset};
            c     <= hit_c;
            d     <= hit_d;
            v     <= hit_v;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module mmu_tb -o mmu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/mmu_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi

echo "pass message not found"
exit 1

// File: tb/mmu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_checker (
    input  logic                        aclk,
    input  logic                        reset,

    // DUT outputs
    input  logic [31:0]                 cp0_rdata,
    input  logic                        inst_found,
    input  logic [31:0]                 inst_paddr,
    input  logic [tlb_pkg::cattr_w-1:0] inst_c,
    input  logic                        inst_d,
    input  logic                        inst_v,
    input  logic                        data_found,
    input  logic [31:0]                 data_paddr,
    input  logic [tlb_pkg::cattr_w-1:0] data_c,
    input  logic                        data_d,
    input  logic                        data_v,

    // expected values from the reference model
    input  logic [31:0]                 exp_rdata,
    input  logic                        exp_inst_found,
    input  logic [31:0]                 exp_inst_paddr,
    input  logic [tlb_pkg::cattr_w-1:0] exp_inst_c,
    input  logic                        exp_inst_d,
    input  logic                        exp_inst_v,
    input  logic                        exp_data_found,
    input  logic [31:0]                 exp_data_paddr,
    input  logic [tlb_pkg::cattr_w-1:0] exp_data_c,
    input  logic                        exp_data_d,
    input  logic                        exp_data_v,

    output int                          errors,
    output int                          checks
);

    initial begin
        errors = 0;
        checks = 0;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: time %0t, %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // outputs are settled by the falling edge, new inputs not yet applied
    always @(negedge aclk) begin
        if (!reset) begin
            check_value("cp0_rdata", exp_rdata, cp0_rdata);
            check_value("inst_found", 32'(exp_inst_found), 32'(inst_found));
            check_value("inst_paddr", exp_inst_paddr, inst_paddr);
            check_value("inst_c", 32'(exp_inst_c), 32'(inst_c));
            check_value("inst_d", 32'(exp_inst_d), 32'(inst_d));
            check_value("inst_v", 32'(exp_inst_v), 32'(inst_v));
            check_value("data_found", 32'(exp_data_found), 32'(data_found));
            check_value("data_paddr", exp_data_paddr, data_paddr);
            check_value("data_c", 32'(exp_data_c), 32'(data_c));
            check_value("data_d", 32'(exp_data_d), 32'(data_d));
            check_value("data_v", 32'(exp_data_v), 32'(data_v));
        end
    end

endmodule

`default_nettype wire

// File: tb/mmu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_tb;

    import tlb_pkg::*;
    import cp0_pkg::*;

    // cycle budget per test section
    localparam int reset_cycles  = 8;
    localparam int regs_cycles   = 12;
    localparam int write_cycles  = 6 * 9;
    localparam int asid_cycles   = 3 * 9;
    localparam int probe_cycles  = 2 * 4 + 10;
    localparam int dup_cycles    = 12;
    localparam int random_cycles = 300;
    localparam int tail_cycles   = 4;
    localparam int cycle_limit   = 2 * (reset_cycles + regs_cycles + write_cycles +
                                        asid_cycles + probe_cycles + dup_cycles +
                                        random_cycles + tail_cycles);

    typedef struct packed {
        logic              found;
        logic [3:0]        idx;
        logic [31:0]       paddr;
        logic [cattr_w-1:0] c;
        logic              d;
        logic              v;
    } xlat_t;

    logic aclk;
    logic reset;
    logic mtc0;
    logic [cp0_sel_w-1:0] cp0_wsel;
    logic [31:0] cp0_wdata;
    logic [cp0_sel_w-1:0] cp0_rsel;
    logic [31:0] cp0_rdata;
    logic tlbwi;
    logic tlbp;
    logic [31:0] inst_vaddr;
    logic inst_found;
    logic [31:0] inst_paddr;
    logic [cattr_w-1:0] inst_c;
    logic inst_d;
    logic inst_v;
    logic [31:0] data_vaddr;
    logic data_found;
    logic [31:0] data_paddr;
    logic [cattr_w-1:0] data_c;
    logic data_d;
    logic data_v;

    // reference model state
    tlb_entry_t  model_tlb [tlb_entries];
    logic [31:0] m_hi;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;
    logic [3:0]  m_index;
    logic        m_p;
    logic        probe_pend;
    xlat_t       probe_hold;
    xlat_t       exp_inst;
    xlat_t       exp_data;
    xlat_t       probe_now;
    tlb_entry_t  new_entry;
    logic [31:0] exp_rdata;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] pages [$];     // entryhi values already written

    mmu_top #(.tlb_entries(tlb_entries)) dut0 (
        .aclk(aclk), .reset(reset),
        .mtc0(mtc0), .cp0_wsel(cp0_wsel), .cp0_wdata(cp0_wdata),
        .cp0_rsel(cp0_rsel), .cp0_rdata(cp0_rdata),
        .tlbwi(tlbwi), .tlbp(tlbp),
        .inst_vaddr(inst_vaddr), .inst_found(inst_found), .inst_paddr(inst_paddr),
        .inst_c(inst_c), .inst_d(inst_d), .inst_v(inst_v),
        .data_vaddr(data_vaddr), .data_found(data_found), .data_paddr(data_paddr),
        .data_c(data_c), .data_d(data_d), .data_v(data_v)
    );

    mmu_checker checker0 (
        .aclk(aclk), .reset(reset), .cp0_rdata(cp0_rdata),
        .inst_found(inst_found), .inst_paddr(inst_paddr),
        .inst_c(inst_c), .inst_d(inst_d), .inst_v(inst_v),
        .data_found(data_found), .data_paddr(data_paddr),
        .data_c(data_c), .data_d(data_d), .data_v(data_v),
        .exp_rdata(exp_rdata),
        .exp_inst_found(exp_inst.found), .exp_inst_paddr(exp_inst.paddr),
        .exp_inst_c(exp_inst.c), .exp_inst_d(exp_inst.d), .exp_inst_v(exp_inst.v),
        .exp_data_found(exp_data.found), .exp_data_paddr(exp_data.paddr),
        .exp_data_c(exp_data.c), .exp_data_d(exp_data.d), .exp_data_v(exp_data.v),
        .errors(errors), .checks(checks)
    );

    always #2 aclk = ~aclk;

    // lowest matching entry wins and va[12] picks the half
    function automatic xlat_t lookup(input logic [31:0] va, input logic [7:0] asid);
        xlat_t r;
        r = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if (!r.found && model_tlb[i].vpn2 == va[31:13] &&
                (model_tlb[i].g || model_tlb[i].asid == asid)) begin
                r.found = 1'b1;
                r.idx   = 4'(i);
                if (va[12]) begin
                    r.paddr = {model_tlb[i].pfn1, va[11:0]};
                    r.c     = model_tlb[i].c1;
                    r.d     = model_tlb[i].d1;
                    r.v     = model_tlb[i].v1;
                end else begin
                    r.paddr = {model_tlb[i].pfn0, va[11:0]};
                    r.c     = model_tlb[i].c0;
                    r.d     = model_tlb[i].d0;
                    r.v     = model_tlb[i].v0;
                end
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] read_reg(input logic [4:0] sel);
        case (sel)
            5'd0:    return {m_p, 27'd0, m_index};
            5'd2:    return m_lo0;
            5'd3:    return m_lo1;
            5'd10:   return m_hi;
            default: return 32'd0;
        endcase
    endfunction

    // model step on the state before the edge
    always @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < tlb_entries; i++) model_tlb[i] = '0;
            m_hi = '0;
            m_lo0 = '0;
            m_lo1 = '0;
            m_index = '0;
            m_p = 1'b0;
            probe_pend = 1'b0;
            probe_hold = '0;
            exp_inst = '0;
            exp_data = '0;
        end else begin
            exp_inst  = lookup(inst_vaddr, m_hi[7:0]);
            exp_data  = lookup(data_vaddr, m_hi[7:0]);
            probe_now = lookup({m_hi[31:13], 13'd0}, m_hi[7:0]);
            new_entry = {m_hi[31:13], m_hi[7:0], m_lo0[0] & m_lo1[0],
                         m_lo0[25:6], m_lo0[5:3], m_lo0[2], m_lo0[1],
                         m_lo1[25:6], m_lo1[5:3], m_lo1[2], m_lo1[1]};
            if (tlbwi) model_tlb[m_index] = new_entry;
            if (mtc0) begin
                case (cp0_wsel)
                    5'd0:  m_index = cp0_wdata[3:0];
                    5'd2:  m_lo0 = cp0_wdata & 32'h03ff_ffff;
                    5'd3:  m_lo1 = cp0_wdata & 32'h03ff_ffff;
                    5'd10: m_hi = cp0_wdata & 32'hffff_e0ff;
                    default: ;
                endcase
            end
            if (probe_pend) begin      // probe result lands one edge late
                m_p = ~probe_hold.found;
                if (probe_hold.found) m_index = probe_hold.idx;
            end
            probe_pend = tlbp;
            probe_hold = probe_now;
        end
        exp_rdata = read_reg(cp0_rsel);
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic drive(input logic m, input logic [4:0] ws, input logic [31:0] wd,
                         input logic [4:0] rs, input logic wi, input logic p,
                         input logic [31:0] iva, input logic [31:0] dva);
        @(negedge aclk);
        mtc0       <= m;
        cp0_wsel   <= ws;
        cp0_wdata  <= wd;
        cp0_rsel   <= rs;
        tlbwi      <= wi;
        tlbp       <= p;
        inst_vaddr <= iva;
        data_vaddr <= dva;
    endtask

    task automatic reg_write(input logic [4:0] sel, input logic [31:0] data);
        drive(1'b1, sel, data, sel, 1'b0, 1'b0, 32'd0, 32'd0);
    endtask

    task automatic look(input logic [31:0] iva, input logic [31:0] dva);
        drive(1'b0, 5'd0, 32'd0, 5'd10, 1'b0, 1'b0, iva, dva);
    endtask

    task automatic tlb_write(input logic [3:0] idx, input logic [31:0] hi,
                             input logic [31:0] lo0, input logic [31:0] lo1);
        reg_write(cp0_sel_index, {28'd0, idx});
        reg_write(cp0_sel_entryhi, hi);
        reg_write(cp0_sel_entrylo0, lo0);
        reg_write(cp0_sel_entrylo1, lo1);
        drive(1'b0, 5'd0, 32'd0, 5'd0, 1'b1, 1'b0, 32'd0, 32'd0);
        pages.push_back(hi);
    endtask

    task automatic probe_and_read(input logic [31:0] hi);
        reg_write(cp0_sel_entryhi, hi);
        drive(1'b0, 5'd0, 32'd0, 5'd0, 1'b0, 1'b1, 32'd0, 32'd0);
        repeat (3) drive(1'b0, 5'd0, 32'd0, 5'd0, 1'b0, 1'b0, 32'd0, 32'd0);
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        logic [31:0] iva;
        logic [31:0] dva;
        logic [4:0]  sel;
        r = $urandom;
        case (r[2:0])
            3'd0:    sel = 5'd0;
            3'd1:    sel = 5'd2;
            3'd2:    sel = 5'd3;
            3'd3:    sel = 5'd10;
            default: sel = r[12:8];
        endcase
        iva = $urandom;
        dva = $urandom;
        if (r[16]) iva = {pages[$urandom % pages.size()][31:13], iva[12:0]};
        if (r[17]) dva = {pages[$urandom % pages.size()][31:13], dva[12:0]};
        drive(r[21:20] == 2'd0, sel, $urandom, r[28:24], r[31:29] == 3'd0,
              r[19:17] == 3'd7, iva, dva);
    endtask

    initial begin
        logic [31:0] hi;
        logic [31:0] va;
        void'($urandom(32'hf7db_afb0));
        aclk = 1'b0;
        reset = 1'b1;
        mtc0 = 1'b0;
        cp0_wsel = '0;
        cp0_wdata = '0;
        cp0_rsel = '0;
        tlbwi = 1'b0;
        tlbp = 1'b0;
        inst_vaddr = '0;
        data_vaddr = '0;
        cycles = 0;
        repeat (reset_cycles) @(negedge aclk);
        reset <= 1'b0;

        // register write and masked read back
        reg_write(cp0_sel_index, $urandom);
        reg_write(cp0_sel_entrylo0, $urandom);
        reg_write(cp0_sel_entrylo1, $urandom);
        reg_write(cp0_sel_entryhi, $urandom);
        look(32'd0, 32'd0);
        drive(1'b0, 5'd0, 32'd0, 5'd5, 1'b0, 1'b0, 32'd0, 32'd0);
        drive(1'b0, 5'd0, 32'd0, 5'd31, 1'b0, 1'b0, 32'd0, 32'd0);

        // random entries with both halves looked up on both ports
        for (int n = 0; n < 6; n++) begin
            hi = $urandom;
            tlb_write(4'($urandom), hi, $urandom, $urandom);
            va = $urandom;
            look({hi[31:13], 1'b0, va[11:0]}, {hi[31:13], 1'b1, va[23:12]});
            look({hi[31:13], 1'b1, va[11:0]}, {hi[31:13], 1'b0, va[23:12]});
            look($urandom, $urandom);
            look(32'd0, 32'd0);
        end

        // asid mismatch with no, one and both g bits set
        for (int g = 0; g < 3; g++) begin
            hi = {$urandom} & 32'hffff_e0ff;
            tlb_write(4'(g + 3), hi, {31'd0, g > 0} | 32'h0000_1fc6,
                      {31'd0, g > 1} | 32'h0100_0fca);
            reg_write(cp0_sel_entryhi, hi ^ 32'h0000_0055);
            look({hi[31:13], 13'h0123}, {hi[31:13], 13'h1abc});
            look(32'd0, 32'd0);
        end

        // probe hit on the non-global entry at index 3, then probe misses
        probe_and_read(pages[6]);
        probe_and_read(32'h0000_2000 ^ pages[6]);
        reg_write(cp0_sel_index, 32'd9);
        probe_and_read(32'hffff_e0aa);
        look(32'd0, 32'd0);

        // the lower of two duplicate entries wins
        hi = $urandom;
        tlb_write(4'd12, hi, $urandom, $urandom);
        tlb_write(4'd7, hi, $urandom, $urandom);
        look({hi[31:13], 13'h0040}, {hi[31:13], 13'h1040});
        look(32'd0, 32'd0);

        repeat (random_cycles) random_cycle();

        repeat (2) look(32'd0, 32'd0);
        @(posedge aclk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/tlb_pkg.sv
design/cp0_pkg.sv
design/tlb_entry_array.sv
design/tlb_search_port.sv
design/cp0_tlb_regs.sv
design/mmu_top.sv
tb/mmu_checker.sv
tb/mmu_tb.sv
